/* design/fc_num_pkg.sv */
// numeric format of the FC engine
// Q16.16 signed words shared by the memory bus and the datapath

package fc_num_pkg;

  // one memory word and one datapath value
  parameter int DATA_WIDTH = 32;

  // fraction bits of the fixed-point format
  parameter int FRAC_BITS = 16;

  typedef logic signed [DATA_WIDTH-1:0] data_t;

endpackage

/* design/fc_ctrl_pkg.sv */
// control definitions of the FC engine
// memory address type, memory map bases and sequencer states

package fc_ctrl_pkg;

  parameter int ADDR_WIDTH = 18;

  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // word-addressed memory map
  parameter addr_t WT1_BASE   = addr_t'(0);       // layer 1 weights in neuron-major order
  parameter addr_t BS1_BASE   = addr_t'(48000);   // layer 1 biases
  parameter addr_t WT2_BASE   = addr_t'(50000);   // layer 2 weights in neuron-major order
  parameter addr_t BS2_BASE   = addr_t'(51200);   // layer 2 biases
  parameter addr_t IFMAP_BASE = addr_t'(65536);   // input vector stored linearly
  parameter addr_t OFMAP_BASE = addr_t'(131072);  // output vector

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,   // read input vector
    ST_MAC1,   // layer 1 weights
    ST_BIAS1,  // layer 1 bias
    ST_MAC2,   // layer 2 weights
    ST_BIAS2,  // layer 2 bias
    ST_DRAIN,  // wait for the last write
    ST_DONE
  } seq_state_e;

endpackage

/* design/fc_feature_buffer.sv */
// rotating shift-register store for one layer's input vector
// push enters at the tail, rotate moves the head to the tail

`timescale 1ns/1ps

module fc_feature_buffer import fc_num_pkg::*; #(
  parameter int DEPTH = 16
) (
  input  logic  clk,
  input  logic  push,
  input  data_t push_data,
  input  logic  rotate,
  output data_t head
);

  data_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (push || rotate) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        mem[i] <= mem[i+1];  // shift toward the head
      end
      mem[DEPTH-1] <= push ? push_data : mem[0];
    end
  end

  assign head = mem[0];

endmodule

/* design/fc_mac_unit.sv */
// fixed-point multiply-accumulate for one layer
// weight and bias registers, Q16.16 product, bias add and ReLU

`timescale 1ns/1ps

module fc_mac_unit import fc_num_pkg::*; (
  input  logic  clk,
  input  logic  srstn,
  input  logic  wt_load,
  input  logic  bs_load,
  input  data_t mem_data,
  input  data_t operand,
  output logic  prod_valid,
  output data_t result,
  output logic  result_valid
);

  data_t wt_q;
  data_t bs_q;
  data_t acc;
  data_t prod;
  data_t biased;

  logic signed [2*DATA_WIDTH-1:0] prod_full;
  logic signed [2*DATA_WIDTH-1:0] prod_shift;

  always_ff @(posedge clk) begin
    if (wt_load) wt_q <= mem_data;
    if (bs_load) bs_q <= mem_data;
  end

  always_ff @(posedge clk) begin
    if (!srstn) begin
      prod_valid   <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      prod_valid   <= wt_load;
      result_valid <= bs_load;
    end
  end

  // full-width product, then drop the extra fraction bits
  assign prod_full  = wt_q * operand;
  assign prod_shift = prod_full >>> FRAC_BITS;
  assign prod       = prod_shift[DATA_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (!srstn) begin
      acc <= '0;
    end else if (result_valid) begin
      acc <= '0;  // next neuron starts from zero
    end else if (prod_valid) begin
      acc <= acc + prod;  // wraps mod 2^32
    end
  end

  assign biased = acc + bs_q;
  assign result = biased[DATA_WIDTH-1] ? '0 : biased;  // relu

endmodule

/* design/fc_layer.sv */
// one fully connected layer
// feature buffer feeding a MAC unit that rotates it once per product

`timescale 1ns/1ps

module fc_layer import fc_num_pkg::*; #(
  parameter int VEC_SIZE = 16
) (
  input  logic  clk,
  input  logic  srstn,
  input  logic  push,
  input  data_t push_data,
  input  logic  wt_load,
  input  logic  bs_load,
  input  data_t mem_data,
  output data_t result,
  output logic  result_valid
);

  data_t head;
  logic  prod_valid;

  fc_feature_buffer #(
    .DEPTH (VEC_SIZE)
  ) u_buffer (
    .clk       (clk),
    .push      (push),
    .push_data (push_data),
    .rotate    (prod_valid),  // head consumed by this product
    .head      (head)
  );

  fc_mac_unit u_mac (
    .clk          (clk),
    .srstn        (srstn),
    .wt_load      (wt_load),
    .bs_load      (bs_load),
    .mem_data     (mem_data),
    .operand      (head),
    .prod_valid   (prod_valid),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

/* design/fc_sequencer.sv */
// run sequencer of the FC engine
// FSM, fetch counters, read/write addressing and load strobes

`timescale 1ns/1ps

module fc_sequencer import fc_ctrl_pkg::*; #(
  parameter int IN_SIZE  = 16,
  parameter int HID_SIZE = 8,
  parameter int OUT_SIZE = 4
) (
  input  logic  clk,
  input  logic  srstn,
  input  logic  start,
  output addr_t addr_in,
  output logic  dram_en_rd,
  output addr_t addr_out,
  output logic  done,
  output logic  ifmap_load,
  output logic  wt1_load,
  output logic  bs1_load,
  output logic  wt2_load,
  output logic  bs2_load
);

  localparam int MAX_LEN = (IN_SIZE > HID_SIZE) ? IN_SIZE : HID_SIZE;
  localparam int MAX_NRN = (HID_SIZE > OUT_SIZE) ? HID_SIZE : OUT_SIZE;
  localparam int IDX_W   = $clog2(MAX_LEN + 1);
  localparam int NRN_W   = $clog2(MAX_NRN + 1);

  seq_state_e state, state_nx;

  logic [IDX_W-1:0] idx_cnt;      // input / weight index within a neuron
  logic [NRN_W-1:0] nrn_cnt;      // neuron index within a layer
  logic             drain_cnt;
  logic [NRN_W-1:0] out_idx_d1;
  logic [NRN_W-1:0] out_idx_d2;

  logic  in_last;
  logic  hid_last;
  logic  l1_nrn_last;
  logic  l2_nrn_last;
  addr_t idx_ext;
  addr_t nrn_ext;

  assign in_last     = (idx_cnt == IDX_W'(IN_SIZE - 1));
  assign hid_last    = (idx_cnt == IDX_W'(HID_SIZE - 1));
  assign l1_nrn_last = (nrn_cnt == NRN_W'(HID_SIZE - 1));
  assign l2_nrn_last = (nrn_cnt == NRN_W'(OUT_SIZE - 1));

  always_ff @(posedge clk) begin
    if (!srstn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nx;
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      ST_IDLE:  if (start) state_nx = ST_LOAD;   // start is ignored elsewhere
      ST_LOAD:  if (in_last) state_nx = ST_MAC1;
      ST_MAC1:  if (in_last) state_nx = ST_BIAS1;
      ST_BIAS1: state_nx = l1_nrn_last ? ST_MAC2 : ST_MAC1;
      ST_MAC2:  if (hid_last) state_nx = ST_BIAS2;
      ST_BIAS2: state_nx = l2_nrn_last ? ST_DRAIN : ST_MAC2;
      ST_DRAIN: if (drain_cnt) state_nx = ST_DONE;  // two cycles
      ST_DONE:  state_nx = ST_IDLE;
      default:  state_nx = ST_IDLE;
    endcase
  end

  // counters wrap to zero on their last value so each phase starts clean
  always_ff @(posedge clk) begin
    if (!srstn) begin
      idx_cnt   <= '0;
      nrn_cnt   <= '0;
      drain_cnt <= 1'b0;
    end else begin
      case (state)
        ST_LOAD, ST_MAC1: idx_cnt <= in_last ? '0 : idx_cnt + 1'b1;
        ST_MAC2:          idx_cnt <= hid_last ? '0 : idx_cnt + 1'b1;
        ST_BIAS1:         nrn_cnt <= l1_nrn_last ? '0 : nrn_cnt + 1'b1;
        ST_BIAS2:         nrn_cnt <= l2_nrn_last ? '0 : nrn_cnt + 1'b1;
        ST_DRAIN:         drain_cnt <= ~drain_cnt;
        default: ;
      endcase
    end
  end

  assign idx_ext = addr_t'(idx_cnt);
  assign nrn_ext = addr_t'(nrn_cnt);

  always_comb begin
    case (state)
      ST_LOAD:  addr_in = IFMAP_BASE + idx_ext;
      ST_MAC1:  addr_in = WT1_BASE + nrn_ext * addr_t'(IN_SIZE) + idx_ext;
      ST_BIAS1: addr_in = BS1_BASE + nrn_ext;
      ST_MAC2:  addr_in = WT2_BASE + nrn_ext * addr_t'(HID_SIZE) + idx_ext;
      ST_BIAS2: addr_in = BS2_BASE + nrn_ext;
      default:  addr_in = '0;
    endcase
  end

  assign dram_en_rd = state inside {ST_LOAD, ST_MAC1, ST_BIAS1, ST_MAC2, ST_BIAS2};
  assign done       = (state == ST_DONE);  // one cycle after the last write

  // strobes line up with data_in, one cycle after the read
  always_ff @(posedge clk) begin
    if (!srstn) begin
      ifmap_load <= 1'b0;
      wt1_load   <= 1'b0;
      bs1_load   <= 1'b0;
      wt2_load   <= 1'b0;
      bs2_load   <= 1'b0;
    end else begin
      ifmap_load <= (state == ST_LOAD);
      wt1_load   <= (state == ST_MAC1);
      bs1_load   <= (state == ST_BIAS1);
      wt2_load   <= (state == ST_MAC2);
      bs2_load   <= (state == ST_BIAS2);
    end
  end

  // layer 2 result leaves two cycles after its bias read
  always_ff @(posedge clk) begin
    if (!srstn) begin
      out_idx_d1 <= '0;
      out_idx_d2 <= '0;
    end else begin
      out_idx_d1 <= nrn_cnt;
      out_idx_d2 <= out_idx_d1;
    end
  end

  assign addr_out = OFMAP_BASE + addr_t'(out_idx_d2);

endmodule

/* design/fc_top.sv */
// top level of the FC inference engine
// sequencer plus two chained layers on the memory ports

`timescale 1ns/1ps

module fc_top import fc_num_pkg::*, fc_ctrl_pkg::*; #(
  parameter int IN_SIZE  = 16,
  parameter int HID_SIZE = 8,
  parameter int OUT_SIZE = 4
) (
  input  logic  clk,
  input  logic  srstn,
  input  logic  start,
  input  data_t data_in,
  output addr_t addr_in,
  output logic  dram_en_rd,
  output addr_t addr_out,
  output logic  dram_en_wr,
  output data_t data_out,
  output logic  done
);

  logic  ifmap_load;
  logic  wt1_load;
  logic  bs1_load;
  logic  wt2_load;
  logic  bs2_load;
  data_t hid_data;
  logic  hid_valid;

  fc_sequencer #(
    .IN_SIZE  (IN_SIZE),
    .HID_SIZE (HID_SIZE),
    .OUT_SIZE (OUT_SIZE)
  ) u_seq (
    .clk        (clk),
    .srstn      (srstn),
    .start      (start),
    .addr_in    (addr_in),
    .dram_en_rd (dram_en_rd),
    .addr_out   (addr_out),
    .done       (done),
    .ifmap_load (ifmap_load),
    .wt1_load   (wt1_load),
    .bs1_load   (bs1_load),
    .wt2_load   (wt2_load),
    .bs2_load   (bs2_load)
  );

  fc_layer #(
    .VEC_SIZE (IN_SIZE)
  ) u_layer1 (
    .clk          (clk),
    .srstn        (srstn),
    .push         (ifmap_load),
    .push_data    (data_in),
    .wt_load      (wt1_load),
    .bs_load      (bs1_load),
    .mem_data     (data_in),
    .result       (hid_data),
    .result_valid (hid_valid)
  );

  // hidden results feed layer 2's buffer directly
  fc_layer #(
    .VEC_SIZE (HID_SIZE)
  ) u_layer2 (
    .clk          (clk),
    .srstn        (srstn),
    .push         (hid_valid),
    .push_data    (hid_data),
    .wt_load      (wt2_load),
    .bs_load      (bs2_load),
    .mem_data     (data_in),
    .result       (data_out),
    .result_valid (dram_en_wr)
  );

endmodule

/* verification/fc_tb.sv */
// testbench for the FC inference engine
// memory model, reference model, directed tests, watchdog and summary

`timescale 1ns/1ps

module fc_tb import fc_num_pkg::*, fc_ctrl_pkg::*;;

  localparam int IN_SIZE  = 16;
  localparam int HID_SIZE = 8;
  localparam int OUT_SIZE = 4;
  localparam int READS    = IN_SIZE + HID_SIZE * (IN_SIZE + 1) + OUT_SIZE * (HID_SIZE + 1);
  localparam int NUM_RUNS = 6;
  localparam longint TIMEOUT_NS = 2 * NUM_RUNS * (READS + 10) * 10;

  logic  clk;
  logic  srstn;
  logic  start;
  data_t data_in = '0;
  addr_t addr_in;
  logic  dram_en_rd;
  addr_t addr_out;
  logic  dram_en_wr;
  data_t data_out;
  logic  done;

  data_t mem [addr_t];
  data_t exp_out [OUT_SIZE];
  addr_t rd_addr_q [$];
  int    rd_cyc_q [$];
  int    start_cyc_q [$];
  addr_t wr_addr_q [$];
  data_t wr_data_q [$];
  int    cyc = 0;
  int    seed;
  int    checks;
  int    errors;

  fc_top #(
    .IN_SIZE  (IN_SIZE),
    .HID_SIZE (HID_SIZE),
    .OUT_SIZE (OUT_SIZE)
  ) DUT (
    .clk        (clk),
    .srstn      (srstn),
    .start      (start),
    .data_in    (data_in),
    .addr_in    (addr_in),
    .dram_en_rd (dram_en_rd),
    .addr_out   (addr_out),
    .dram_en_wr (dram_en_wr),
    .data_out   (data_out),
    .done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic data_t mem_rd(addr_t a);
    return mem.exists(a) ? mem[a] : '0;  // unwritten words read as zero
  endfunction

  // memory answers one cycle after the read, and logs reads, writes and starts
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (start) start_cyc_q.push_back(cyc);
    if (dram_en_rd) begin
      data_in <= mem_rd(addr_in);
      rd_addr_q.push_back(addr_in);
      rd_cyc_q.push_back(cyc);
    end else begin
      data_in <= '0;
    end
    if (dram_en_wr) begin
      wr_addr_q.push_back(addr_out);
      wr_data_q.push_back(data_out);
    end
  end

  function automatic data_t rand_val(int mag);
    return data_t'($random(seed) % mag);
  endfunction

  function automatic data_t relu(data_t v);
    return (v < 0) ? '0 : v;
  endfunction

  // Q16.16 product with the extra fraction bits dropped
  function automatic data_t fixed_mul(data_t a, data_t b);
    longint p;
    p = longint'(a) * longint'(b);
    p = p >>> FRAC_BITS;
    return data_t'(p);
  endfunction

  function automatic void compute_model();
    data_t hid [HID_SIZE];
    data_t acc;
    for (int n = 0; n < HID_SIZE; n++) begin
      acc = '0;
      for (int k = 0; k < IN_SIZE; k++) begin
        acc = acc + fixed_mul(mem_rd(WT1_BASE + addr_t'(n * IN_SIZE + k)),
                              mem_rd(IFMAP_BASE + addr_t'(k)));
      end
      hid[n] = relu(acc + mem_rd(BS1_BASE + addr_t'(n)));
    end
    for (int m = 0; m < OUT_SIZE; m++) begin
      acc = '0;
      for (int k = 0; k < HID_SIZE; k++) begin
        acc = acc + fixed_mul(mem_rd(WT2_BASE + addr_t'(m * HID_SIZE + k)), hid[k]);
      end
      exp_out[m] = relu(acc + mem_rd(BS2_BASE + addr_t'(m)));
    end
  endfunction

  // inputs within +-2.0, weights and biases within +-1.0
  task automatic fill_memory();
    mem.delete();
    for (int i = 0; i < IN_SIZE; i++) mem[IFMAP_BASE + addr_t'(i)] = rand_val(131072);
    for (int i = 0; i < HID_SIZE * IN_SIZE; i++) mem[WT1_BASE + addr_t'(i)] = rand_val(65536);
    for (int i = 0; i < HID_SIZE; i++) mem[BS1_BASE + addr_t'(i)] = rand_val(65536);
    for (int i = 0; i < OUT_SIZE * HID_SIZE; i++) mem[WT2_BASE + addr_t'(i)] = rand_val(65536);
    for (int i = 0; i < OUT_SIZE; i++) mem[BS2_BASE + addr_t'(i)] = rand_val(65536);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  task automatic launch_run();
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    logic prev_wr;
    prev_wr = 1'b0;
    @(posedge clk);
    while (!done) begin
      prev_wr = dram_en_wr;
      @(posedge clk);
    end
    checks++;
    if (!prev_wr) begin
      errors++;
      $display("%0t: done did not come one cycle after the last write", $time);
    end
  endtask

  // read order and count, then the output writes against exp_out
  task automatic check_run();
    addr_t exp_addr [$];
    for (int i = 0; i < IN_SIZE; i++) exp_addr.push_back(IFMAP_BASE + addr_t'(i));
    for (int n = 0; n < HID_SIZE; n++) begin
      for (int k = 0; k < IN_SIZE; k++) exp_addr.push_back(WT1_BASE + addr_t'(n * IN_SIZE + k));
      exp_addr.push_back(BS1_BASE + addr_t'(n));
    end
    for (int m = 0; m < OUT_SIZE; m++) begin
      for (int k = 0; k < HID_SIZE; k++) exp_addr.push_back(WT2_BASE + addr_t'(m * HID_SIZE + k));
      exp_addr.push_back(BS2_BASE + addr_t'(m));
    end
    check_value("read count", rd_addr_q.size(), READS);
    if (rd_addr_q.size() == READS) begin
      for (int i = 0; i < READS; i++) check_value("addr_in", rd_addr_q[i], exp_addr[i]);
      check_value("read span", rd_cyc_q[READS-1] - rd_cyc_q[0] + 1, READS);
      check_value("first read cycle", rd_cyc_q[0], start_cyc_q[0] + 1);
    end
    check_value("write count", wr_addr_q.size(), OUT_SIZE);
    if (wr_addr_q.size() == OUT_SIZE) begin
      for (int m = 0; m < OUT_SIZE; m++) begin
        check_value("addr_out", wr_addr_q[m], OFMAP_BASE + addr_t'(m));
        check_value("data_out", wr_data_q[m], exp_out[m]);
      end
    end
    rd_addr_q.delete();
    rd_cyc_q.delete();
    start_cyc_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
  endtask

  task automatic run_once();
    launch_run();
    wait_done();
    check_run();
    @(posedge clk);
    check_value("done", done, 1'b0);  // single-cycle pulse
  endtask

  task automatic test_reset_idle();
    repeat (20) begin
      @(posedge clk);
      check_value("dram_en_rd", dram_en_rd, 1'b0);
      check_value("dram_en_wr", dram_en_wr, 1'b0);
      check_value("done", done, 1'b0);
      check_value("addr_in", addr_in, '0);
    end
  endtask

  task automatic test_read_schedule();
    fill_memory();
    compute_model();
    run_once();
  endtask

  task automatic test_random_inference();
    fill_memory();
    compute_model();
    run_once();
  endtask

  task automatic test_relu();
    data_t b2;
    // hidden layer forced to zero by large negative biases
    fill_memory();
    for (int n = 0; n < HID_SIZE; n++) begin
      mem[BS1_BASE + addr_t'(n)] = -(data_t'(100) <<< FRAC_BITS) - rand_val(65536);
    end
    for (int m = 0; m < OUT_SIZE; m++) begin
      b2 = mem_rd(BS2_BASE + addr_t'(m));
      exp_out[m] = (b2 > 0) ? b2 : '0;
    end
    run_once();
    // non-negative hidden values against non-positive layer 2 weights
    fill_memory();
    foreach (mem[a]) begin
      if (a >= WT2_BASE && a < IFMAP_BASE) begin
        mem[a] = (mem[a] < 0) ? mem[a] : -mem[a];
      end else begin
        mem[a] = (mem[a] < 0) ? -mem[a] : mem[a];
      end
    end
    for (int m = 0; m < OUT_SIZE; m++) exp_out[m] = '0;
    run_once();
  endtask

  task automatic test_done_back_to_back();
    fill_memory();
    compute_model();
    launch_run();
    repeat (5) @(posedge clk);
    launch_run();  // lands in ST_LOAD and must be ignored
    wait_done();
    check_run();
    fill_memory();
    compute_model();
    launch_run();
    check_value("done", done, 1'b0);
    wait_done();
    check_run();
    repeat (5) @(posedge clk);
    check_value("reads after run", rd_addr_q.size(), 0);
  endtask

  initial begin
    seed   = 32'hf503;
    checks = 0;
    errors = 0;
    srstn  = 1'b0;
    start  = 1'b0;
    repeat (3) @(posedge clk);
    srstn <= 1'b1;
    test_reset_idle();
    test_read_schedule();
    test_random_inference();
    test_relu();
    test_done_back_to_back();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("watchdog timeout at %0t, sequencer in state %s", $time,
             DUT.u_seq.state.name());
    $display("checks: %0d  errors: %0d", checks, errors + 1);
    $display("Errors found");
    $finish;
  end

endmodule

/* fc_engine.f */
design/fc_num_pkg.sv
design/fc_ctrl_pkg.sv
design/fc_feature_buffer.sv
design/fc_mac_unit.sv
design/fc_layer.sv
design/fc_sequencer.sv
design/fc_top.sv
verification/fc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fc_engine simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f fc_engine.f \
  --top-module fc_tb \
  -o fc_sim

./obj_dir/fc_sim | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
